//--- gb_core_bus.f
hw/gb_pkg.sv
hw/gb_mem_map.sv
hw/gb_irq_ctrl.sv
hw/gb_joypad.sv
hw/gb_serial.sv
hw/gb_ram.sv
hw/gb_core_bus.sv
tb/gb_core_bus_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = gb_core_bus_tb
FILELIST = gb_core_bus.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

# pass or fail comes from the log, not from the simulator status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/gb_core_bus_tb.sv
// testbench for the console bus glue, plays the cpu side of the bus struct
// runs ram, interrupt, joypad, serial and cartridge tests, then prints the counts
module gb_core_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000;   // serial transfer is about 4k of it
	localparam int SERIAL_WAIT = gb_pkg::SERIAL_BITS * gb_pkg::SERIAL_BIT_DIV + 64;

	logic clk;
	logic reset;
	gb_pkg::cpu_bus_t cpu;
	gb_pkg::byte_t cpu_rdata;
	logic irq_n;
	logic cgb_mode;
	logic fast_boot;
	gb_pkg::byte_t joystick;
	logic [2:0] ext_irq;                     // timer, lcd, vblank
	gb_pkg::addr_t cart_addr;
	logic cart_rd;
	logic cart_wr;
	gb_pkg::byte_t cart_wdata;
	gb_pkg::byte_t cart_rdata;
	logic cart_rd_exp;
	logic cart_wr_exp;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_err0 = 0;                       // error count when the test began
	int cycle_cnt = 0;
	gb_pkg::byte_t zp_model [int];
	gb_pkg::byte_t wram_model [int];         // keyed by bank * 4k + offset
	gb_pkg::addr_t zp_addr [$];
	gb_pkg::addr_t ent_addr [$];
	int ent_bank [$];

	gb_core_bus u_gb_core_bus (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.cpu_rdata  (cpu_rdata),
		.irq_n      (irq_n),
		.cgb_mode   (cgb_mode),
		.fast_boot  (fast_boot),
		.joystick   (joystick),
		.ext_irq    (ext_irq),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_wdata (cart_wdata),
		.cart_rdata (cart_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	// ------------------------------------------------------------
	// expected values from the memory map
	function automatic logic in_cart(gb_pkg::addr_t a);
		return (a <= 16'h7FFF) || ((a >= 16'hA000) && (a <= 16'hBFFF)); // rom or cart ram
	endfunction

	function automatic int wram_key(int bank, gb_pkg::addr_t a);
		return a[12] ? bank * 4096 + int'(a[11:0]) : int'(a[11:0]); // c000-cfff is bank 0
	endfunction

	function automatic int lowest_index(gb_pkg::irq_vec_t pend);
		int i;
		i = 0;
		while (i < gb_pkg::IRQ_W && !pend[i])
			i++;
		return i;                            // IRQ_W when nothing pending
	endfunction

	// p4 lines carry down, up, left, right; a select bit of 1 masks its group
	function automatic gb_pkg::byte_t joy_expect(logic [1:0] p54, gb_pkg::byte_t j);
		logic [3:0] dirs;
		logic [3:0] btns;
		dirs = p54[0] ? 4'hF : ~{j[2], j[3], j[1], j[0]};
		btns = p54[1] ? 4'hF : ~j[7:4];
		return {2'b11, p54, dirs & btns};
	endfunction

	assign cart_rd_exp = cpu.rd && in_cart(cpu.addr);
	assign cart_wr_exp = cpu.wr && in_cart(cpu.addr);

	a_cart_strobe: assert property (@(posedge clk) disable iff (reset)
		{cart_rd, cart_wr} == {cart_rd_exp, cart_wr_exp})
	else begin
		errors++;
		$display("Mismatch at %0t ns: cart_rd/cart_wr got %b expected %b", $time,
			$sampled({cart_rd, cart_wr}), $sampled({cart_rd_exp, cart_wr_exp}));
	end

	a_cart_bus: assert property (@(posedge clk) disable iff (reset)
		(cart_rd || cart_wr) |-> ({cart_addr, cart_wdata} == {cpu.addr, cpu.wdata}))
	else begin
		errors++;
		$display("Mismatch at %0t ns: cart_addr/cart_wdata got %h expected %h", $time,
			$sampled({cart_addr, cart_wdata}), $sampled({cpu.addr, cpu.wdata}));
	end

	// ------------------------------------------------------------
	// bus tasks, everything driven on the rising edge
	task automatic check_byte(string name, gb_pkg::byte_t got, gb_pkg::byte_t exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Mismatch at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic bus_write(gb_pkg::addr_t a, gb_pkg::byte_t d);
		@(posedge clk);
		cpu <= '{addr: a, wdata: d, rd: 1'b0, wr: 1'b1, ack: 1'b0};
		@(posedge clk);                      // write lands on this edge
		cpu <= '0;
	endtask

	// hold 2 for the rams, their data is registered
	task automatic read_check(string name, gb_pkg::addr_t a, int hold, gb_pkg::byte_t exp);
		@(posedge clk);
		cpu <= '{addr: a, wdata: 8'h00, rd: 1'b1, wr: 1'b0, ack: 1'b0};
		repeat (hold - 1) @(posedge clk);
		@(negedge clk);
		check_byte(name, cpu_rdata, exp);
		@(posedge clk);
		cpu <= '0;
	endtask

	task automatic ack_cycle(output gb_pkg::byte_t vec);
		@(posedge clk);
		cpu <= '{addr: 16'h0000, wdata: 8'h00, rd: 1'b0, wr: 1'b0, ack: 1'b1};
		@(negedge clk);
		vec = cpu_rdata;
		@(posedge clk);                      // flag clears on the next edge
		cpu <= '0;
	endtask

	// hold a read of IF until the bit shows up or the limit runs out
	task automatic wait_flag(int bit_idx, int limit, string what);
		int n;
		n = 0;
		@(posedge clk);
		cpu <= '{addr: gb_pkg::ADDR_IF, wdata: 8'h00, rd: 1'b1, wr: 1'b0, ack: 1'b0};
		do begin
			@(negedge clk);
			n++;
		end while (!cpu_rdata[bit_idx] && n < limit);
		checks++;
		assert (cpu_rdata[bit_idx])
		else begin
			errors++;
			$display("%s did not set IF bit %0d within %0d cycles", what, bit_idx, limit);
		end
		@(posedge clk);
		cpu <= '0;
	endtask

	task automatic end_test(string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	// ------------------------------------------------------------
	// stimulus
	initial begin
		gb_pkg::addr_t a;
		gb_pkg::byte_t d;
		gb_pkg::byte_t j;
		gb_pkg::irq_vec_t ie_v;
		gb_pkg::irq_vec_t if_v;
		gb_pkg::irq_vec_t if_exp;
		int idx;
		int banks [3];
		banks = '{1, 3, 7};
		void'($urandom(71571));
		reset = 1'b1;
		cpu = '0;
		cgb_mode = 1'b1;
		fast_boot = 1'b1;
		joystick = 8'h00;
		ext_irq = 3'b000;
		cart_rdata = 8'h00;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// ram, zero page then three work-ram banks
		for (int k = 0; k < 8; k++) begin
			a = 16'hFF80 + gb_pkg::addr_t'($urandom_range(0, 126));
			d = gb_pkg::byte_t'($urandom);
			bus_write(a, d);
			zp_model[int'(a[6:0])] = d;
			zp_addr.push_back(a);
		end
		foreach (banks[b]) begin
			bus_write(gb_pkg::ADDR_SVBK, gb_pkg::byte_t'(banks[b]));
			for (int k = 0; k < 8; k++) begin
				a = {(k < 2) ? 4'hC : 4'hD, 12'($urandom)};  // a couple in bank 0
				d = gb_pkg::byte_t'($urandom);
				bus_write(a, d);
				wram_model[wram_key(banks[b], a)] = d;
				ent_addr.push_back(a);
				ent_bank.push_back(banks[b]);
			end
		end
		foreach (zp_addr[e])
			read_check("zpram", zp_addr[e], 2, zp_model[int'(zp_addr[e][6:0])]);
		foreach (ent_addr[e]) begin
			bus_write(gb_pkg::ADDR_SVBK, gb_pkg::byte_t'(ent_bank[e]));
			read_check("wram", ent_addr[e], 2, wram_model[wram_key(ent_bank[e], ent_addr[e])]);
		end
		bus_write(gb_pkg::ADDR_SVBK, 8'h00);          // bank 0 aliases 1
		foreach (ent_addr[e])
			if (ent_bank[e] == 1)
				read_check("wram bank 0 alias", ent_addr[e], 2,
					wram_model[wram_key(1, ent_addr[e])]);
		bus_write(gb_pkg::ADDR_SVBK, 8'h03);          // colour bank left at 3
		@(posedge clk);
		cgb_mode <= 1'b0;
		bus_write(gb_pkg::ADDR_SVBK, 8'h07);          // ignored outside colour mode
		foreach (ent_addr[e])
			if (ent_bank[e] == 1)
				read_check("wram dmg", ent_addr[e], 2, wram_model[wram_key(1, ent_addr[e])]);
		@(posedge clk);
		cgb_mode <= 1'b1;                             // bank 3 still selected
		foreach (ent_addr[e])
			if (ent_bank[e] == 3)
				read_check("wram svbk kept", ent_addr[e], 2,
					wram_model[wram_key(3, ent_addr[e])]);
		end_test("ram");

		// interrupts
		bus_write(gb_pkg::ADDR_IE, 8'h05);
		bus_write(gb_pkg::ADDR_IF, 8'h02);
		@(negedge clk);
		check_byte("irq_n", {7'd0, irq_n}, 8'h01);    // no overlap
		bus_write(gb_pkg::ADDR_IF, 8'h06);
		@(negedge clk);
		check_byte("irq_n", {7'd0, irq_n}, 8'h00);
		for (int k = 0; k < 6; k++) begin
			ie_v = gb_pkg::irq_vec_t'($urandom) | 5'h10;  // joypad always pending
			if_v = gb_pkg::irq_vec_t'($urandom) | 5'h10;
			bus_write(gb_pkg::ADDR_IE, {3'b000, ie_v});
			bus_write(gb_pkg::ADDR_IF, {3'b000, if_v});
			idx = lowest_index(ie_v & if_v);
			ack_cycle(d);
			check_byte("ack vector", d,
				gb_pkg::IRQ_VEC_BASE + gb_pkg::byte_t'(gb_pkg::IRQ_VEC_STEP * idx));
			if_exp = if_v;
			if_exp[idx] = 1'b0;                       // only the acked flag drops
			read_check("if after ack", gb_pkg::ADDR_IF, 1, {3'b111, if_exp});
			read_check("ie", gb_pkg::ADDR_IE, 1, {3'b000, ie_v});
		end
		bus_write(gb_pkg::ADDR_IF, 8'h00);
		@(negedge clk);
		check_byte("irq_n", {7'd0, irq_n}, 8'h01);
		ack_cycle(d);
		check_byte("ack vector", d, gb_pkg::IRQ_VEC_NONE);
		@(posedge clk);
		ext_irq <= 3'b001;                            // vblank alone
		@(posedge clk);
		ext_irq <= 3'b000;
		read_check("if", gb_pkg::ADDR_IF, 1, 8'hE1);
		@(posedge clk);
		ext_irq <= 3'b110;                            // timer and lcd
		@(posedge clk);
		ext_irq <= 3'b000;
		read_check("if", gb_pkg::ADDR_IF, 1, 8'hE7);
		end_test("interrupts");

		// joypad matrix
		for (int s = 0; s < 4; s++) begin
			bus_write(gb_pkg::ADDR_JOY, gb_pkg::byte_t'(s << 4));
			for (int k = 0; k < 4; k++) begin
				j = gb_pkg::byte_t'($urandom);
				@(posedge clk);
				joystick <= j;
				read_check("joy", gb_pkg::ADDR_JOY, 1, joy_expect(2'(s), j));
			end
		end
		bus_write(gb_pkg::ADDR_JOY, 8'h10);           // buttons only
		@(posedge clk);
		joystick <= 8'h00;
		repeat (4) @(posedge clk);                    // let the line delay settle
		bus_write(gb_pkg::ADDR_IF, 8'h00);
		@(posedge clk);
		joystick <= 8'h10;                            // press a button
		wait_flag(4, 16, "button press");
		end_test("joypad");

		// serial, internal clock
		bus_write(gb_pkg::ADDR_IF, 8'h00);
		bus_write(gb_pkg::ADDR_SC, 8'h81);
		read_check("sc busy", gb_pkg::ADDR_SC, 1, 8'hFF);  // start, 3fh, internal clock
		read_check("sb", gb_pkg::ADDR_SB, 1, gb_pkg::OPEN_BUS);
		wait_flag(3, SERIAL_WAIT, "serial transfer");
		read_check("sc done", gb_pkg::ADDR_SC, 1, 8'h7F);
		read_check("sb", gb_pkg::ADDR_SB, 1, gb_pkg::OPEN_BUS);
		end_test("serial");

		// cartridge port and boot flag
		for (int k = 0; k < 8; k++) begin
			a = k[0] ? {3'b101, 13'($urandom)} : {1'b0, 15'($urandom)};
			d = gb_pkg::byte_t'($urandom);
			@(posedge clk);
			cart_rdata <= d;
			read_check("cart read", a, 1, d);
			bus_write(a, gb_pkg::byte_t'($urandom));   // strobes watched by a_cart_*
		end
		read_check("ff50", gb_pkg::ADDR_BOOT, 1, gb_pkg::FAST_BOOT_FLAG);
		bus_write(gb_pkg::ADDR_BOOT, 8'h01);
		read_check("ff50", gb_pkg::ADDR_BOOT, 1, gb_pkg::OPEN_BUS);
		end_test("cartridge and boot");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- hw/gb_core_bus.sv
// system-bus glue of the console: decode, ram, i/o and interrupts
// the cpu side drives cpu_bus_t, three interrupt sources come from outside
module gb_core_bus (
	input logic clk,
	input logic reset,
	input gb_pkg::cpu_bus_t cpu,
	output gb_pkg::byte_t cpu_rdata,
	output logic irq_n,
	input logic cgb_mode,
	input logic fast_boot,
	input gb_pkg::byte_t joystick,
	input logic [2:0] ext_irq,             // timer, lcd, vblank
	output gb_pkg::addr_t cart_addr,
	output logic cart_rd,
	output logic cart_wr,
	output gb_pkg::byte_t cart_wdata,
	input gb_pkg::byte_t cart_rdata
);

	gb_pkg::unit_sel_t sel;
	gb_pkg::byte_t joy_rdata;
	gb_pkg::byte_t sc_rdata;
	gb_pkg::byte_t ie_rdata;
	gb_pkg::byte_t if_rdata;
	gb_pkg::byte_t ram_rdata;
	gb_pkg::byte_t irq_vector;
	logic joy_irq;
	logic serial_irq;

	// ------------------------------------------------------------
	// decode and read mux
	gb_mem_map u_gb_mem_map (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.fast_boot  (fast_boot),
		.joy_rdata  (joy_rdata),
		.sc_rdata   (sc_rdata),
		.ie_rdata   (ie_rdata),
		.if_rdata   (if_rdata),
		.ram_rdata  (ram_rdata),
		.irq_vector (irq_vector),
		.cart_rdata (cart_rdata),
		.sel        (sel),
		.cpu_rdata  (cpu_rdata),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_wdata (cart_wdata)
	);

	// request bits in priority order, vblank at bit 0
	gb_irq_ctrl u_gb_irq_ctrl (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.sel        (sel),
		.irq_req    ({joy_irq, serial_irq, ext_irq}),
		.irq_n      (irq_n),
		.irq_vector (irq_vector),
		.ie_rdata   (ie_rdata),
		.if_rdata   (if_rdata)
	);

	gb_joypad u_gb_joypad (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.sel        (sel),
		.joystick   (joystick),
		.joy_rdata  (joy_rdata),
		.joy_irq    (joy_irq)
	);

	gb_serial u_gb_serial (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.sel        (sel),
		.sc_rdata   (sc_rdata),
		.serial_irq (serial_irq)
	);

	gb_ram u_gb_ram (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.sel        (sel),
		.cgb_mode   (cgb_mode),
		.ram_rdata  (ram_rdata)
	);

endmodule

//--- hw/gb_ram.sv
// zero-page ram and banked work ram, both with registered read data
// svbk banking at ff70 only takes effect in colour mode
module gb_ram (
	input logic clk,
	input logic reset,
	input gb_pkg::cpu_bus_t cpu,
	input gb_pkg::unit_sel_t sel,
	input logic cgb_mode,
	output gb_pkg::byte_t ram_rdata
);

	gb_pkg::byte_t zpram [2**gb_pkg::ZPRAM_AW];
	gb_pkg::byte_t wram [2**gb_pkg::WRAM_AW];

	gb_pkg::wram_bank_t bank_r;    // 1..7
	gb_pkg::wram_bank_t bank_eff;
	logic [gb_pkg::WRAM_AW-1:0] wram_addr;
	gb_pkg::byte_t zp_q;
	gb_pkg::byte_t wram_q;
	logic zp_sel_q;                // which array the last read came from

	// ------------------------------------------------------------
	// bank register
	always_ff @(posedge clk) begin
		if (reset)
			bank_r <= 3'd1;
		else if ((cpu.addr == gb_pkg::ADDR_SVBK) && cpu.wr && cgb_mode) begin
			if (cpu.wdata[2:0] == 3'd0)
				bank_r <= 3'd1;    // bank 0 aliases 1
			else
				bank_r <= cpu.wdata[2:0];
		end
	end

	assign bank_eff = cgb_mode ? bank_r : 3'd1;    // dmg sees a fixed 8k

	// c000-cfff bank 0, d000-dfff switched
	assign wram_addr = cpu.addr[12] ? {bank_eff, cpu.addr[11:0]} : {3'd0, cpu.addr[11:0]};

	// ------------------------------------------------------------
	// arrays
	always_ff @(posedge clk) begin
		if (sel.zpram && cpu.wr)
			zpram[cpu.addr[gb_pkg::ZPRAM_AW-1:0]] <= cpu.wdata;
		zp_q <= zpram[cpu.addr[gb_pkg::ZPRAM_AW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (sel.wram && cpu.wr)
			wram[wram_addr] <= cpu.wdata;
		wram_q <= wram[wram_addr];
	end

	always_ff @(posedge clk) begin
		if (reset)
			zp_sel_q <= 1'b0;
		else
			zp_sel_q <= sel.zpram;
	end

	assign ram_rdata = zp_sel_q ? zp_q : wram_q;

	a_bank_nonzero: assert property (@(posedge clk) disable iff (reset) bank_r != 3'd0);

endmodule

//--- hw/gb_serial.sv
// dummy serial port, only the control register at ff02 is real
// an internal-clock transfer counts eight bit times and raises the irq
module gb_serial (
	input logic clk,
	input logic reset,
	input gb_pkg::cpu_bus_t cpu,
	input gb_pkg::unit_sel_t sel,
	output gb_pkg::byte_t sc_rdata,
	output logic serial_irq
);

	gb_pkg::serial_state_t state;
	logic sc_start;           // sc bit 7
	logic sc_shiftclock;      // sc bit 0, 1 = internal clock
	gb_pkg::ser_div_t div_cnt;
	gb_pkg::ser_cnt_t bit_cnt;
	logic sc_wr;

	assign sc_wr = sel.sc && cpu.wr;

	always_ff @(posedge clk) begin
		serial_irq <= 1'b0;   // single cycle pulse
		if (reset) begin
			state <= gb_pkg::SER_IDLE;
			sc_start <= 1'b0;
			sc_shiftclock <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (sc_wr) begin
			sc_start <= cpu.wdata[7];
			sc_shiftclock <= cpu.wdata[0];
			div_cnt <= gb_pkg::ser_div_t'(gb_pkg::SERIAL_BIT_DIV - 1);
			bit_cnt <= gb_pkg::ser_cnt_t'(gb_pkg::SERIAL_BITS);
			// external clock never arrives, so only internal shifts
			if (cpu.wdata[7] && cpu.wdata[0])
				state <= gb_pkg::SER_SHIFT;
			else
				state <= gb_pkg::SER_IDLE;
		end else if (state == gb_pkg::SER_SHIFT) begin
			if (div_cnt == '0) begin
				div_cnt <= gb_pkg::ser_div_t'(gb_pkg::SERIAL_BIT_DIV - 1);
				bit_cnt <= bit_cnt - 1'b1;
				if (bit_cnt == gb_pkg::ser_cnt_t'(1)) begin   // last bit out
					serial_irq <= 1'b1;
					sc_start <= 1'b0;
					state <= gb_pkg::SER_IDLE;
				end
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	assign sc_rdata = {sc_start, 6'h3F, sc_shiftclock};

endmodule

//--- hw/gb_joypad.sv
// joypad matrix register at ff00 and its interrupt on a falling line
// joystick inputs are active high, the matrix is active low
module gb_joypad (
	input logic clk,
	input logic reset,
	input gb_pkg::cpu_bus_t cpu,
	input gb_pkg::unit_sel_t sel,
	input gb_pkg::byte_t joystick,
	output gb_pkg::byte_t joy_rdata,
	output logic joy_irq
);

	logic [1:0] p54;          // group select, 1 masks the group
	logic [3:0] joy_p4;       // directions
	logic [3:0] joy_p5;       // buttons
	gb_pkg::byte_t line_d1;
	gb_pkg::byte_t line_d2;

	// down, up, left, right order on the p4 lines
	assign joy_p4 = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_p5 = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	assign joy_rdata = {2'b11, p54, joy_p4 & joy_p5};

	always_ff @(posedge clk) begin
		if (reset) begin
			p54 <= 2'b00;
			line_d1 <= '1;        // lines idle high
			line_d2 <= '1;
			joy_irq <= 1'b0;
		end else begin
			if (sel.joy && cpu.wr)
				p54 <= cpu.wdata[5:4];
			// two-stage delay on all eight lines
			line_d1 <= {joy_p4, joy_p5};
			line_d2 <= line_d1;
			joy_irq <= |(~line_d1 & line_d2); // any 1 to 0 change
		end
	end

endmodule

//--- hw/gb_irq_ctrl.sv
// interrupt enable and flag registers with the priority vector
// flags clear on the write of IF or on the falling edge of ack
module gb_irq_ctrl (
	input logic clk,
	input logic reset,
	input gb_pkg::cpu_bus_t cpu,
	input gb_pkg::unit_sel_t sel,
	input gb_pkg::irq_vec_t irq_req,
	output logic irq_n,
	output gb_pkg::byte_t irq_vector,
	output gb_pkg::byte_t ie_rdata,
	output gb_pkg::byte_t if_rdata
);

	gb_pkg::irq_vec_t ie_r;
	gb_pkg::irq_vec_t if_r;
	gb_pkg::irq_vec_t pend;       // enabled and flagged
	gb_pkg::irq_vec_t pend_low;   // lowest pending bit only
	gb_pkg::irq_vec_t ack_clr;
	logic ack_q;                  // ack level one cycle ago
	logic ack_fall;

	assign pend = ie_r & if_r;
	assign pend_low = pend & (~pend + gb_pkg::irq_vec_t'(1)); // isolate lowest set bit
	assign ack_fall = ack_q && !cpu.ack;
	assign ack_clr = ack_fall ? pend_low : '0;

	// low as long as anything enabled is pending
	assign irq_n = pend == '0;

	// ------------------------------------------------------------
	// vector, bit 0 wins
	always_comb begin
		irq_vector = gb_pkg::IRQ_VEC_NONE;
		for (int i = gb_pkg::IRQ_W - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vector = gb_pkg::IRQ_VEC_BASE + gb_pkg::byte_t'(gb_pkg::IRQ_VEC_STEP * i);
		end
	end

	// ------------------------------------------------------------
	// registers
	always_ff @(posedge clk) begin
		if (reset) begin
			ie_r <= '0;
			if_r <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= cpu.ack;
			if (sel.ie && cpu.wr)
				ie_r <= cpu.wdata[gb_pkg::IRQ_W-1:0];
			// cpu write overrides both request and ack clear
			if (sel.iflag && cpu.wr)
				if_r <= cpu.wdata[gb_pkg::IRQ_W-1:0];
			else
				if_r <= (if_r | irq_req) & ~ack_clr;
		end
	end

	// upper bits: ie reads 0, if reads 1
	assign ie_rdata = {3'b000, ie_r};
	assign if_rdata = {3'b111, if_r};

	// quiet cycle with nothing enabled pending keeps irq_n high
	a_irq_idle: assert property (@(posedge clk) disable iff (reset)
		(pend == '0) && (irq_req == '0) && !(cpu.wr && (sel.ie || sel.iflag)) |=> irq_n);

endmodule

//--- hw/gb_mem_map.sv
// address decode and cpu read mux for the console memory map
// also owns the boot latch at ff50 and the cartridge port strobes
module gb_mem_map (
	input logic clk,
	input logic reset,
	input gb_pkg::cpu_bus_t cpu,
	input logic fast_boot,
	input gb_pkg::byte_t joy_rdata,
	input gb_pkg::byte_t sc_rdata,
	input gb_pkg::byte_t ie_rdata,
	input gb_pkg::byte_t if_rdata,
	input gb_pkg::byte_t ram_rdata,
	input gb_pkg::byte_t irq_vector,
	input gb_pkg::byte_t cart_rdata,
	output gb_pkg::unit_sel_t sel,
	output gb_pkg::byte_t cpu_rdata,
	output gb_pkg::addr_t cart_addr,
	output logic cart_rd,
	output logic cart_wr,
	output gb_pkg::byte_t cart_wdata
);

	logic boot_enabled;    // cleared once by software
	logic sel_boot;
	logic sel_fast;

	// ------------------------------------------------------------
	// decode
	always_comb begin
		sel.joy = cpu.addr == gb_pkg::ADDR_JOY;
		sel.sb = cpu.addr == gb_pkg::ADDR_SB;
		sel.sc = cpu.addr == gb_pkg::ADDR_SC;
		sel.ie = cpu.addr == gb_pkg::ADDR_IE;
		sel.iflag = cpu.addr == gb_pkg::ADDR_IF;
		sel.zpram = (cpu.addr[15:7] == 9'h1FF) && (cpu.addr != gb_pkg::ADDR_IE); // ff80-fffe
		sel.wram = cpu.addr[15:13] == 3'b110;                    // c000-dfff
		sel.cart = !cpu.addr[15] || (cpu.addr[15:13] == 3'b101); // rom + cart ram
	end

	assign sel_boot = cpu.addr == gb_pkg::ADDR_BOOT;
	assign sel_fast = fast_boot && sel_boot && boot_enabled; // boot code polls 42h here

	// writing bit 0 of ff50 disables boot mode for good
	always_ff @(posedge clk) begin
		if (reset)
			boot_enabled <= 1'b1;
		else if (sel_boot && cpu.wr && cpu.wdata[0])
			boot_enabled <= 1'b0;
	end

	// ------------------------------------------------------------
	// read mux, ack vector first
	always_comb begin
		if (cpu.ack)
			cpu_rdata = irq_vector;
		else if (sel_fast)
			cpu_rdata = gb_pkg::FAST_BOOT_FLAG;
		else if (sel.joy)
			cpu_rdata = joy_rdata;
		else if (sel.sb)
			cpu_rdata = gb_pkg::OPEN_BUS;       // dummy serial data
		else if (sel.sc)
			cpu_rdata = sc_rdata;
		else if (sel.cart)
			cpu_rdata = cart_rdata;
		else if (sel.zpram || sel.wram)
			cpu_rdata = ram_rdata;              // registered in the ram unit
		else if (sel.ie)
			cpu_rdata = ie_rdata;
		else if (sel.iflag)
			cpu_rdata = if_rdata;
		else
			cpu_rdata = gb_pkg::OPEN_BUS;
	end

	// cartridge port, straight from the cpu
	assign cart_addr = cpu.addr;
	assign cart_wdata = cpu.wdata;
	assign cart_rd = sel.cart && cpu.rd;
	assign cart_wr = sel.cart && cpu.wr;    // mbc register writes land in rom space

	// units must never fight over the read mux
	a_sel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(sel));

endmodule

//--- hw/gb_pkg.sv
// shared types and memory-map constants for the console system bus
// referenced by scoped name from every unit of the bus glue
package gb_pkg;

	// ------------------------------------------------------------
	// widths
	localparam int IRQ_W = 5;               // vblank, lcd, timer, serial, joypad
	localparam int ZPRAM_AW = 7;            // 127 bytes used of 128
	localparam int WRAM_AW = 15;            // 8 banks of 4k
	localparam int SERIAL_BIT_DIV = 512;    // clocks per serial bit
	localparam int SERIAL_BITS = 8;
	localparam int SERIAL_DIV_W = $clog2(SERIAL_BIT_DIV);
	localparam int SERIAL_CNT_W = $clog2(SERIAL_BITS + 1);

	typedef logic [15:0] addr_t;            // cpu address
	typedef logic [7:0] byte_t;             // data byte
	typedef logic [IRQ_W-1:0] irq_vec_t;    // bit 0 = vblank, highest priority
	typedef logic [2:0] wram_bank_t;        // svbk bank number
	typedef logic [SERIAL_DIV_W-1:0] ser_div_t;
	typedef logic [SERIAL_CNT_W-1:0] ser_cnt_t;

	// ------------------------------------------------------------
	// i/o register addresses
	localparam addr_t ADDR_JOY = 16'hFF00;
	localparam addr_t ADDR_SB = 16'hFF01;
	localparam addr_t ADDR_SC = 16'hFF02;
	localparam addr_t ADDR_IF = 16'hFF0F;
	localparam addr_t ADDR_BOOT = 16'hFF50;
	localparam addr_t ADDR_SVBK = 16'hFF70;  // cgb only
	localparam addr_t ADDR_IE = 16'hFFFF;

	localparam byte_t IRQ_VEC_BASE = 8'h40;  // rst vector of vblank
	localparam int IRQ_VEC_STEP = 8;
	localparam byte_t IRQ_VEC_NONE = 8'h55;  // ack with nothing pending
	localparam byte_t FAST_BOOT_FLAG = 8'h42;
	localparam byte_t OPEN_BUS = 8'hFF;

	// bus from the cpu side, levels valid for the whole cycle
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic rd;
		logic wr;
		logic ack;    // interrupt acknowledge cycle
	} cpu_bus_t;

	// one-hot unit selects out of the address decoder
	typedef struct packed {
		logic joy;
		logic sb;
		logic sc;
		logic ie;
		logic iflag;
		logic zpram;
		logic wram;
		logic cart;   // rom and cart ram regions
	} unit_sel_t;

	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} serial_state_t;

endpackage
